// ==== ebusPkg.sv ====
package ebusPkg;

  // bus and address widths
  localparam int EbusWidth = 32;
  localparam int UnitWidth = 2;
  localparam int RegWidth = 2;
  localparam int AxiAddrWidth = 8;

  // unit select codes come from AXI address bits 5:4
  typedef enum logic [UnitWidth-1:0] {
    UnitTimer   = 2'd0,
    UnitCond    = 2'd1,
    UnitScratch = 2'd2,
    UnitNone    = 2'd3
  } unitT;

  typedef enum logic {
    FuncRead  = 1'b0,
    FuncWrite = 1'b1
  } ebusFuncT;

  typedef enum logic [2:0] {
    HostIdle,
    HostWrResp,
    HostRdDemand,
    HostRdCapture,
    HostRdResp
  } hostStateT;

  // interval timer register indices
  localparam logic [RegWidth-1:0] TmrPeriod = 2'd0;
  localparam logic [RegWidth-1:0] TmrCount = 2'd1;
  localparam logic [RegWidth-1:0] TmrCtrl = 2'd2;
  localparam logic [RegWidth-1:0] TmrDone = 2'd3;

  // condition flag register indices
  localparam logic [RegWidth-1:0] CondFlags = 2'd0;
  localparam logic [RegWidth-1:0] CondSet = 2'd1;
  localparam logic [RegWidth-1:0] CondClear = 2'd2;
  localparam logic [RegWidth-1:0] CondEnable = 2'd3;

endpackage

// ==== ebusHost.sv ====
module ebusHost import ebusPkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [AxiAddrWidth-1:0] awaddr,
  input  logic                    awvalid,
  output logic                    awready,
  input  logic [EbusWidth-1:0]    wdata,
  input  logic [EbusWidth/8-1:0]  wstrb,
  input  logic                    wvalid,
  output logic                    wready,
  output logic [1:0]              bresp,
  output logic                    bvalid,
  input  logic                    bready,
  input  logic [AxiAddrWidth-1:0] araddr,
  input  logic                    arvalid,
  output logic                    arready,
  output logic [EbusWidth-1:0]    rdata,
  output logic [1:0]              rresp,
  output logic                    rvalid,
  input  logic                    rready,
  output unitT                    ebusUnit,
  output logic [RegWidth-1:0]     ebusReg,
  output ebusFuncT                ebusFunc,
  output logic [EbusWidth-1:0]    ebusWrData,
  output logic                    ebusDemand,
  input  logic [EbusWidth-1:0]    ebusData
);

  hostStateT state;
  logic wrAccept;
  logic rdAccept;

  // a write needs both address and data present, and it wins over a read
  assign wrAccept = (state == HostIdle) && awvalid && wvalid;
  assign rdAccept = (state == HostIdle) && arvalid && !(awvalid && wvalid);

  assign awready = wrAccept;
  assign wready = wrAccept;
  assign arready = rdAccept;

  // every access completes, so responses are always OKAY
  assign bresp = 2'b00;
  assign rresp = 2'b00;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= HostIdle;
      ebusDemand <= 1'b0;
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      // the demand strobe follows the accepting edge by one cycle
      ebusDemand <= wrAccept || rdAccept;
      case (state)
        HostIdle: begin
          if (wrAccept) begin
            state <= HostWrResp;
          end else if (rdAccept) begin
            state <= HostRdDemand;
          end
        end
        HostWrResp: begin
          // the unit takes the write at the end of the demand cycle
          if (ebusDemand) begin
            bvalid <= 1'b1;
          end else if (bvalid && bready) begin
            bvalid <= 1'b0;
            state <= HostIdle;
          end
        end
        HostRdDemand: begin
          state <= HostRdCapture;
        end
        HostRdCapture: begin
          rvalid <= 1'b1;
          state <= HostRdResp;
        end
        HostRdResp: begin
          if (rready) begin
            rvalid <= 1'b0;
            state <= HostIdle;
          end
        end
        default: begin
          state <= HostIdle;
        end
      endcase
    end
  end

  // request fields are latched from whichever channel is accepted
  // wstrb is not decoded since the units only take full words
  always_ff @(posedge clk) begin
    if (wrAccept) begin
      ebusUnit <= unitT'(awaddr[5:4]);
      ebusReg <= awaddr[3:2];
      ebusFunc <= FuncWrite;
      ebusWrData <= wdata;
    end else if (rdAccept) begin
      ebusUnit <= unitT'(araddr[5:4]);
      ebusReg <= araddr[3:2];
      ebusFunc <= FuncRead;
    end
    // the merged bus carries the unit's word during the capture state
    if (state == HostRdCapture) begin
      rdata <= ebusData;
    end
  end

  demandPulse: assert property (@(posedge clk) disable iff (rst)
    ebusDemand |=> !ebusDemand);

  // a stalled read response must not move until the host takes it
  rdHold: assert property (@(posedge clk) disable iff (rst)
    rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

// ==== intervalTimer.sv ====
module intervalTimer import ebusPkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  unitT                 ebusUnit,
  input  logic [RegWidth-1:0]  ebusReg,
  input  ebusFuncT             ebusFunc,
  input  logic [EbusWidth-1:0] ebusWrData,
  input  logic                 ebusDemand,
  output logic                 driving,
  output logic [EbusWidth-1:0] data,
  output logic                 timerDone
);

  logic [EbusWidth-1:0] period;
  logic [EbusWidth-1:0] count;
  logic enable;
  logic wrHit;
  logic rdHit;
  logic [EbusWidth-1:0] readValue;

  assign wrHit = ebusDemand && (ebusUnit == UnitTimer) && (ebusFunc == FuncWrite);
  assign rdHit = ebusDemand && (ebusUnit == UnitTimer) && (ebusFunc == FuncRead);

  always_comb begin
    case (ebusReg)
      TmrPeriod: readValue = period;
      TmrCount:  readValue = count;
      TmrCtrl:   readValue = {{(EbusWidth-1){1'b0}}, enable};
      default:   readValue = {{(EbusWidth-1){1'b0}}, timerDone};
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      period <= '0;
      count <= '0;
      enable <= 1'b0;
      timerDone <= 1'b0;
      driving <= 1'b0;
    end else begin
      // a zero period holds the counter where it is
      // wrapping on >= keeps the count bounded if the period shrinks
      if (enable && (period != '0)) begin
        if (count >= period) begin
          count <= '0;
          timerDone <= 1'b1;
        end else begin
          count <= count + 1'b1;
        end
      end
      // host writes take priority over the counter in the same cycle
      if (wrHit) begin
        case (ebusReg)
          TmrPeriod: period <= ebusWrData;
          TmrCount:  count <= ebusWrData;
          TmrCtrl:   enable <= ebusWrData[0];
          default:   timerDone <= 1'b0;
        endcase
      end
      driving <= rdHit;
    end
  end

  always_ff @(posedge clk) begin
    data <= readValue;
  end

endmodule

// ==== condFlags.sv ====
module condFlags import ebusPkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  unitT                 ebusUnit,
  input  logic [RegWidth-1:0]  ebusReg,
  input  ebusFuncT             ebusFunc,
  input  logic [EbusWidth-1:0] ebusWrData,
  input  logic                 ebusDemand,
  input  logic                 timerDone,
  output logic                 driving,
  output logic [EbusWidth-1:0] data,
  output logic                 irq
);

  logic [EbusWidth-1:0] flags;
  logic [EbusWidth-1:0] enable;
  logic [EbusWidth-1:0] flagsNext;
  logic [EbusWidth-1:0] enableNext;
  logic wrHit;
  logic rdHit;

  assign wrHit = ebusDemand && (ebusUnit == UnitCond) && (ebusFunc == FuncWrite);
  assign rdHit = ebusDemand && (ebusUnit == UnitCond) && (ebusFunc == FuncRead);

  // set, then clear, then the timer's hardware set on bit 0
  always_comb begin
    flagsNext = flags;
    enableNext = enable;
    if (wrHit && (ebusReg == CondSet)) flagsNext = flagsNext | ebusWrData;
    if (wrHit && (ebusReg == CondClear)) flagsNext = flagsNext & ~ebusWrData;
    if (wrHit && (ebusReg == CondEnable)) enableNext = ebusWrData;
    flagsNext[0] = flagsNext[0] | timerDone;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
      enable <= '0;
      irq <= 1'b0;
      driving <= 1'b0;
    end else begin
      flags <= flagsNext;
      enable <= enableNext;
      // irq tracks the registered flags and mask with no extra lag
      irq <= |(flagsNext & enableNext);
      driving <= rdHit;
    end
  end

  // the enable index reads the mask, every other index reads the flags
  always_ff @(posedge clk) begin
    data <= (ebusReg == CondEnable) ? enable : flags;
  end

  irqMasked: assert property (@(posedge clk) disable iff (rst)
    (enable == '0) |-> !irq);

endmodule

// ==== scratchRegs.sv ====
module scratchRegs import ebusPkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  unitT                 ebusUnit,
  input  logic [RegWidth-1:0]  ebusReg,
  input  ebusFuncT             ebusFunc,
  input  logic [EbusWidth-1:0] ebusWrData,
  input  logic                 ebusDemand,
  output logic                 driving,
  output logic [EbusWidth-1:0] data
);

  localparam int NumWords = 1 << RegWidth;

  // known words for the host to exercise the bus path
  logic [EbusWidth-1:0] words [NumWords];
  logic wrHit;
  logic rdHit;

  assign wrHit = ebusDemand && (ebusUnit == UnitScratch) && (ebusFunc == FuncWrite);
  assign rdHit = ebusDemand && (ebusUnit == UnitScratch) && (ebusFunc == FuncRead);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NumWords; i++) begin
        words[i] <= '0;
      end
      driving <= 1'b0;
    end else begin
      if (wrHit) begin
        words[ebusReg] <= ebusWrData;
      end
      driving <= rdHit;
    end
  end

  always_ff @(posedge clk) begin
    data <= words[ebusReg];
  end

endmodule

// ==== ebusTop.sv ====
module ebusTop import ebusPkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [AxiAddrWidth-1:0] awaddr,
  input  logic                    awvalid,
  output logic                    awready,
  input  logic [EbusWidth-1:0]    wdata,
  input  logic [EbusWidth/8-1:0]  wstrb,
  input  logic                    wvalid,
  output logic                    wready,
  output logic [1:0]              bresp,
  output logic                    bvalid,
  input  logic                    bready,
  input  logic [AxiAddrWidth-1:0] araddr,
  input  logic                    arvalid,
  output logic                    arready,
  output logic [EbusWidth-1:0]    rdata,
  output logic [1:0]              rresp,
  output logic                    rvalid,
  input  logic                    rready,
  output logic                    irq
);

  // request broadcast from the bridge to every unit
  unitT ebusUnit;
  logic [RegWidth-1:0] ebusReg;
  ebusFuncT ebusFunc;
  logic [EbusWidth-1:0] ebusWrData;
  logic ebusDemand;
  logic [EbusWidth-1:0] ebusData;

  // per-unit driver records
  logic timerDriving;
  logic [EbusWidth-1:0] timerData;
  logic timerDone;
  logic condDriving;
  logic [EbusWidth-1:0] condData;
  logic scratchDriving;
  logic [EbusWidth-1:0] scratchData;

  ebusHost u_host (.*);

  intervalTimer u_timer (
    .clk, .rst, .ebusUnit, .ebusReg, .ebusFunc, .ebusWrData, .ebusDemand,
    .driving(timerDriving), .data(timerData), .timerDone
  );

  condFlags u_cond (
    .clk, .rst, .ebusUnit, .ebusReg, .ebusFunc, .ebusWrData, .ebusDemand, .timerDone,
    .driving(condDriving), .data(condData), .irq
  );

  scratchRegs u_scratch (
    .clk, .rst, .ebusUnit, .ebusReg, .ebusFunc, .ebusWrData, .ebusDemand,
    .driving(scratchDriving), .data(scratchData)
  );

  // fixed priority merge, an idle bus reads as zero
  always_comb begin
    if (timerDriving) ebusData = timerData;
    else if (condDriving) ebusData = condData;
    else if (scratchDriving) ebusData = scratchData;
    else ebusData = '0;
  end

  singleDriver: assert property (@(posedge clk) disable iff (rst)
    $onehot0({timerDriving, condDriving, scratchDriving}));

endmodule

// ==== ebusTb.sv ====
module ebusTb import ebusPkg::*; ();

  logic clk = 1'b0;
  logic rst;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready, irq;
  logic [AxiAddrWidth-1:0] awaddr, araddr;
  logic [EbusWidth-1:0] wdata, rdata;
  logic [EbusWidth/8-1:0] wstrb;
  logic [1:0] bresp, rresp;
  integer seed = 32'h2c5f_0c20;
  int cycles = 0;
  int errorCount = 0;
  logic [EbusWidth-1:0] scratchExp [4];

  ebusTop u_ebusTop (.*);

  always #50 clk = ~clk;

  // the timer poll at its bound of 100 is the longest part, roughly 1000 cycles
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= 3000) begin
      $display("timeout: the tests did not finish within 3000 cycles");
      reportFailure();
    end
  end

  task automatic reportFailure();
    errorCount++;
    $display("Done: errors found");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic expectWord(string name, logic [EbusWidth-1:0] got,
                            logic [EbusWidth-1:0] exp);
    assert (got === exp) else begin
      $display("[FAIL] time %0t: %s is %h, expected %h", $time, name, got, exp);
      reportFailure();
    end
  endtask

  // inputs change and outputs are sampled 10 units after each rising edge
  task automatic nextCycle();
    @(posedge clk);
    #10;
  endtask

  // unit sits in address bits 5:4 and the register in bits 3:2
  function automatic logic [AxiAddrWidth-1:0] addrOf(logic [1:0] unit, logic [1:0] regIdx);
    return {2'b00, unit, regIdx, 2'b00};
  endfunction

  task automatic axiWrite(logic [1:0] unit, logic [1:0] regIdx, logic [EbusWidth-1:0] value);
    awaddr = addrOf(unit, regIdx);
    awvalid = 1'b1;
    wdata = value;
    wvalid = 1'b1;
    // the ready lines are combinational, so let them settle first
    #1;
    while (!(awready && wready)) nextCycle();
    nextCycle();
    awvalid = 1'b0;
    wvalid = 1'b0;
    bready = 1'b1;
    while (!bvalid) nextCycle();
    expectWord("bresp", 32'(bresp), 32'd0);
    nextCycle();
    bready = 1'b0;
  endtask

  // address phase of a read, returns once the response is valid
  task automatic readRequest(logic [1:0] unit, logic [1:0] regIdx);
    araddr = addrOf(unit, regIdx);
    arvalid = 1'b1;
    #1;
    while (!arready) nextCycle();
    nextCycle();
    arvalid = 1'b0;
    while (!rvalid) nextCycle();
  endtask

  task automatic readAccept();
    rready = 1'b1;
    expectWord("rresp", 32'(rresp), 32'd0);
    nextCycle();
    rready = 1'b0;
  endtask

  task automatic axiRead(logic [1:0] unit, logic [1:0] regIdx,
                         output logic [EbusWidth-1:0] value);
    readRequest(unit, regIdx);
    value = rdata;
    readAccept();
  endtask

  task automatic compareScratch();
    logic [EbusWidth-1:0] value;
    for (int i = 0; i < 4; i++) begin
      axiRead(UnitScratch, 2'(i), value);
      expectWord("scratch word", value, scratchExp[i]);
    end
  endtask

  task automatic checkAfterReset();
    expectWord("bvalid", 32'(bvalid), 32'd0);
    expectWord("rvalid", 32'(rvalid), 32'd0);
    expectWord("irq", 32'(irq), 32'd0);
    for (int i = 0; i < 4; i++) begin
      scratchExp[i] = '0;
    end
    compareScratch();
  endtask

  task automatic scratchRoundTrip();
    for (int i = 0; i < 4; i++) begin
      scratchExp[i] = $random(seed);
      axiWrite(UnitScratch, 2'(i), scratchExp[i]);
    end
    compareScratch();
  endtask

  // nobody answers unit code 3, so the merged bus reads as zero
  task automatic unmappedUnit();
    logic [EbusWidth-1:0] value;
    axiRead(UnitNone, 2'd0, value);
    expectWord("unmapped read", value, 32'd0);
    value = $random(seed);
    axiWrite(UnitNone, 2'd1, value);
    compareScratch();
    axiRead(UnitCond, CondFlags, value);
    expectWord("CondFlags", value, 32'd0);
    // the timer is stopped, so its count only moves if that write landed there
    axiRead(UnitTimer, TmrCount, value);
    expectWord("TmrCount", value, 32'd0);
  endtask

  task automatic condFlagSequence();
    logic [EbusWidth-1:0] mask;
    logic [EbusWidth-1:0] subset;
    logic [EbusWidth-1:0] value;
    // bit 8 survives the partial clear and later drives the interrupt
    mask = $random(seed) | 32'h100;
    subset = $random(seed) & mask & ~32'h100;
    axiWrite(UnitCond, CondSet, mask);
    axiRead(UnitCond, CondFlags, value);
    expectWord("CondFlags", value, mask);
    axiWrite(UnitCond, CondClear, subset);
    axiRead(UnitCond, CondFlags, value);
    expectWord("CondFlags", value, mask & ~subset);
    axiWrite(UnitCond, CondEnable, 32'h100);
    expectWord("irq", 32'(irq), 32'd1);
    axiWrite(UnitCond, CondClear, 32'h100);
    expectWord("irq", 32'(irq), 32'd0);
    axiWrite(UnitCond, CondClear, '1);
    axiWrite(UnitCond, CondEnable, 32'd0);
  endtask

  task automatic timerCountdown();
    logic [EbusWidth-1:0] value;
    int polls;
    axiWrite(UnitTimer, TmrPeriod, 32'd8);
    axiWrite(UnitTimer, TmrCtrl, 32'd1);
    value = '0;
    polls = 0;
    while ((value != 32'd1) && (polls < 100)) begin
      axiRead(UnitTimer, TmrCount, value);
      assert (value <= 32'd8) else begin
        $display("[FAIL] time %0t: TmrCount is %0d, expected at most 8", $time, value);
        reportFailure();
      end
      axiRead(UnitTimer, TmrDone, value);
      polls++;
    end
    assert (value == 32'd1) else begin
      $display("the timer never reported done within 100 polls");
      reportFailure();
    end
    // the done flag feeds condition flag bit 0 in hardware
    axiRead(UnitCond, CondFlags, value);
    expectWord("CondFlags bit 0", 32'(value[0]), 32'd1);
    axiWrite(UnitCond, CondEnable, 32'd1);
    expectWord("irq", 32'(irq), 32'd1);
    axiWrite(UnitTimer, TmrCtrl, 32'd0);
    axiWrite(UnitTimer, TmrDone, 32'd0);
    axiRead(UnitTimer, TmrDone, value);
    expectWord("TmrDone", value, 32'd0);
    axiWrite(UnitCond, CondClear, 32'd1);
    axiWrite(UnitCond, CondEnable, 32'd0);
    expectWord("irq", 32'(irq), 32'd0);
  endtask

  task automatic stalledRead();
    scratchExp[1] = $random(seed);
    axiWrite(UnitScratch, 2'd1, scratchExp[1]);
    readRequest(UnitScratch, 2'd1);
    expectWord("rdata", rdata, scratchExp[1]);
    // with rready held low the response has to sit still
    repeat (5) begin
      nextCycle();
      expectWord("rvalid", 32'(rvalid), 32'd1);
      expectWord("rdata", rdata, scratchExp[1]);
    end
    readAccept();
    expectWord("rvalid", 32'(rvalid), 32'd0);
  endtask

  initial begin
    rst = 1'b1;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '1;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    repeat (5) @(posedge clk);
    #10;
    rst = 1'b0;
    checkAfterReset();
    scratchRoundTrip();
    unmappedUnit();
    condFlagSequence();
    timerCountdown();
    stalledRead();
    if (errorCount == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
ebusPkg.sv
ebusHost.sv
intervalTimer.sv
condFlags.sv
scratchRegs.sv
ebusTop.sv
ebusTb.sv

// ==== Makefile ====
# build the testbench with Verilator, run it and search the log for the result
sim:
	verilator --binary --timing --assert -f tb.f --top-module ebusTb -o ebusSim
	./obj_dir/ebusSim | tee sim.log
	@if grep -q "Done: errors found" sim.log; then exit 1; fi
	@grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
